//--- rtl/mips_pkg.sv
/*
 * shared constants for the single-cycle mips core
 * widths, reset pc, opcodes and funct codes
 * alu, pc and write-back select encodings
 * instruction word union with r, i and j views
 */

package mips_pkg;

   // datapath and address widths
   localparam int XLEN    = 32;
   localparam int WADDR_W = 30;
   localparam int REG_W   = 5;

   // jal writes the return address here
   localparam logic [REG_W-1:0] REG_RA = 5'd31;

   // start of the text segment, nextpc resets one word later
   localparam logic [XLEN-1:0] TEXT_START = 32'h0040_0000;

   // primary opcodes
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_J       = 6'h02;
   localparam logic [5:0] OP_JAL     = 6'h03;
   localparam logic [5:0] OP_BEQ     = 6'h04;
   localparam logic [5:0] OP_BNE     = 6'h05;
   localparam logic [5:0] OP_ADDI    = 6'h08;
   localparam logic [5:0] OP_ADDIU   = 6'h09;
   localparam logic [5:0] OP_SLTI    = 6'h0a;
   localparam logic [5:0] OP_ANDI    = 6'h0c;
   localparam logic [5:0] OP_ORI     = 6'h0d;
   localparam logic [5:0] OP_XORI    = 6'h0e;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_SW      = 6'h2b;

   // funct field of special instructions
   localparam logic [5:0] FN_SLL     = 6'h00;
   localparam logic [5:0] FN_SRL     = 6'h02;
   localparam logic [5:0] FN_SRA     = 6'h03;
   localparam logic [5:0] FN_JR      = 6'h08;
   localparam logic [5:0] FN_SYSCALL = 6'h0c;
   localparam logic [5:0] FN_ADD     = 6'h20;
   localparam logic [5:0] FN_ADDU    = 6'h21;
   localparam logic [5:0] FN_SUB     = 6'h22;
   localparam logic [5:0] FN_SUBU    = 6'h23;
   localparam logic [5:0] FN_AND     = 6'h24;
   localparam logic [5:0] FN_OR      = 6'h25;
   localparam logic [5:0] FN_XOR     = 6'h26;
   localparam logic [5:0] FN_NOR     = 6'h27;
   localparam logic [5:0] FN_SLT     = 6'h2a;

   // alu operation select
   localparam int ALU_SEL_W = 4;
   localparam logic [ALU_SEL_W-1:0] ALU_ADD = 4'd0;
   localparam logic [ALU_SEL_W-1:0] ALU_SUB = 4'd1;
   localparam logic [ALU_SEL_W-1:0] ALU_AND = 4'd2;
   localparam logic [ALU_SEL_W-1:0] ALU_OR  = 4'd3;
   localparam logic [ALU_SEL_W-1:0] ALU_XOR = 4'd4;
   localparam logic [ALU_SEL_W-1:0] ALU_NOR = 4'd5;
   localparam logic [ALU_SEL_W-1:0] ALU_SLT = 4'd6;
   localparam logic [ALU_SEL_W-1:0] ALU_SLL = 4'd7;
   localparam logic [ALU_SEL_W-1:0] ALU_SRL = 4'd8;
   localparam logic [ALU_SEL_W-1:0] ALU_SRA = 4'd9;
   localparam logic [ALU_SEL_W-1:0] ALU_LUI = 4'd10;

   // source of the value loaded into nextpc
   localparam int PC_SEL_W = 2;
   localparam logic [PC_SEL_W-1:0] PC_SEQ    = 2'd0;
   localparam logic [PC_SEL_W-1:0] PC_BRANCH = 2'd1;
   localparam logic [PC_SEL_W-1:0] PC_JREG   = 2'd2;
   localparam logic [PC_SEL_W-1:0] PC_JUMP   = 2'd3;

   // register write-back source
   localparam int WB_SEL_W = 2;
   localparam logic [WB_SEL_W-1:0] WB_ALU  = 2'd0;
   localparam logic [WB_SEL_W-1:0] WB_MEM  = 2'd1;
   localparam logic [WB_SEL_W-1:0] WB_LINK = 2'd2;

   // one instruction word seen in the three mips formats
   typedef union packed {
      struct packed {
         logic [5:0] op;
         logic [4:0] rs;
         logic [4:0] rt;
         logic [4:0] rd;
         logic [4:0] shamt;
         logic [5:0] funct;
      } r;
      struct packed {
         logic [5:0]  op;
         logic [4:0]  rs;
         logic [4:0]  rt;
         logic [15:0] imm;
      } i;
      struct packed {
         logic [5:0]  op;
         logic [25:0] target;
      } j;
   } instr_t;

endpackage

//--- rtl/mips_decode.sv
/*
 * instruction decoder
 * maps opcode and funct to datapath controls
 * raises a halt request on syscall or unknown encodings
 */

`timescale 1ns/1ps

module mips_decode (
   input  mips_pkg::instr_t                  inst,
   output logic [mips_pkg::ALU_SEL_W-1:0]    alu_sel,
   output logic                              alu_src_imm,
   output logic                              imm_signed,
   output logic                              reg_dst_rd,
   output logic                              reg_we,
   output logic [mips_pkg::WB_SEL_W-1:0]     wb_sel,
   output logic                              mem_we,
   output logic [mips_pkg::PC_SEL_W-1:0]     pc_sel,
   output logic                              branch_ne,
   output logic                              link,
   output logic                              halt_req
);

   always_comb
   begin
      // defaults describe a harmless nop
      alu_sel     = mips_pkg::ALU_ADD;
      alu_src_imm = 1'b0;
      imm_signed  = 1'b1;
      reg_dst_rd  = 1'b0;
      reg_we      = 1'b0;
      wb_sel      = mips_pkg::WB_ALU;
      mem_we      = 1'b0;
      pc_sel      = mips_pkg::PC_SEQ;
      branch_ne   = 1'b0;
      link        = 1'b0;
      halt_req    = 1'b0;

      case (inst.r.op)
         mips_pkg::OP_SPECIAL:
         begin
            // r-type writes rd unless the funct says otherwise
            reg_dst_rd = 1'b1;
            reg_we     = 1'b1;
            case (inst.r.funct)
               mips_pkg::FN_SLL:  alu_sel = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL:  alu_sel = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA:  alu_sel = mips_pkg::ALU_SRA;
               // no overflow trap, add behaves as addu
               mips_pkg::FN_ADD,
               mips_pkg::FN_ADDU: alu_sel = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUB,
               mips_pkg::FN_SUBU: alu_sel = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_sel = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_sel = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  alu_sel = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  alu_sel = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  alu_sel = mips_pkg::ALU_SLT;
               mips_pkg::FN_JR:
               begin
                  reg_we = 1'b0;
                  pc_sel = mips_pkg::PC_JREG;
               end
               // syscall and unknown funct both stop the core
               default:
               begin
                  reg_we   = 1'b0;
                  halt_req = 1'b1;
               end
            endcase
         end
         mips_pkg::OP_J:
            pc_sel = mips_pkg::PC_JUMP;
         mips_pkg::OP_JAL:
         begin
            pc_sel = mips_pkg::PC_JUMP;
            link   = 1'b1;
            reg_we = 1'b1;
            wb_sel = mips_pkg::WB_LINK;
         end
         // branches compare rs with rt, operand b stays on rt
         mips_pkg::OP_BEQ:
            pc_sel = mips_pkg::PC_BRANCH;
         mips_pkg::OP_BNE:
         begin
            pc_sel    = mips_pkg::PC_BRANCH;
            branch_ne = 1'b1;
         end
         mips_pkg::OP_ADDI,
         mips_pkg::OP_ADDIU:
         begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         mips_pkg::OP_SLTI:
         begin
            alu_sel     = mips_pkg::ALU_SLT;
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         // logic immediates are zero extended
         mips_pkg::OP_ANDI,
         mips_pkg::OP_ORI,
         mips_pkg::OP_XORI:
         begin
            alu_sel     = (inst.i.op == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                          (inst.i.op == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR  :
                                                             mips_pkg::ALU_XOR;
            alu_src_imm = 1'b1;
            imm_signed  = 1'b0;
            reg_we      = 1'b1;
         end
         mips_pkg::OP_LUI:
         begin
            alu_sel     = mips_pkg::ALU_LUI;
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
         end
         // address is rs plus sign extended offset
         mips_pkg::OP_LW:
         begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
            wb_sel      = mips_pkg::WB_MEM;
         end
         mips_pkg::OP_SW:
         begin
            alu_src_imm = 1'b1;
            mem_we      = 1'b1;
         end
         default:
            halt_req = 1'b1;
      endcase
   end

endmodule

//--- rtl/mips_alu.sv
/*
 * integer alu
 * add, sub, logic ops, shifts, signed compare and lui
 * equality flag for beq and bne
 */

`timescale 1ns/1ps

module mips_alu (
   input  logic [mips_pkg::XLEN-1:0]      op_a,
   input  logic [mips_pkg::XLEN-1:0]      op_b,
   input  logic [mips_pkg::REG_W-1:0]     shamt,
   input  logic [mips_pkg::ALU_SEL_W-1:0] alu_sel,
   output logic [mips_pkg::XLEN-1:0]      result,
   output logic                           branch_eq
);

   // always rs against the second operand, branches keep rt there
   assign branch_eq = (op_a == op_b);

   always_comb
   begin
      case (alu_sel)
         mips_pkg::ALU_ADD: result = op_a + op_b;
         mips_pkg::ALU_SUB: result = op_a - op_b;
         mips_pkg::ALU_AND: result = op_a & op_b;
         mips_pkg::ALU_OR:  result = op_a | op_b;
         mips_pkg::ALU_XOR: result = op_a ^ op_b;
         mips_pkg::ALU_NOR: result = ~(op_a | op_b);
         // signed compare for slt and slti
         mips_pkg::ALU_SLT:
         begin
            result = {{(mips_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
         end
         // shifts move rt by the shamt field
         mips_pkg::ALU_SLL: result = op_b << shamt;
         mips_pkg::ALU_SRL: result = op_b >> shamt;
         mips_pkg::ALU_SRA: result = $signed(op_b) >>> shamt;
         // immediate goes to the upper half
         mips_pkg::ALU_LUI: result = {op_b[15:0], 16'h0000};
         default:           result = '0;
      endcase
   end

endmodule

//--- rtl/mips_regfile.sv
/*
 * 32 x 32 register file
 * two combinational reads, one write port
 */

`timescale 1ns/1ps

module mips_regfile (
   input  logic                       clk,
   input  logic [mips_pkg::REG_W-1:0] rs_addr,
   input  logic [mips_pkg::REG_W-1:0] rt_addr,
   input  logic [mips_pkg::REG_W-1:0] rd_addr,
   input  logic [mips_pkg::XLEN-1:0]  rd_data,
   input  logic                       we,
   output logic [mips_pkg::XLEN-1:0]  rs_data,
   output logic [mips_pkg::XLEN-1:0]  rt_data
);

   logic [mips_pkg::XLEN-1:0] regs [32];

   // writes to r0 are dropped
   always_ff @(posedge clk)
   begin
      if (we && (rd_addr != '0))
         regs[rd_addr] <= rd_data;
   end

   // r0 reads as zero whatever the array holds
   assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- rtl/mips_fetch.sv
/*
 * pc and nextpc registers giving one delay slot
 * next-pc selection with branch and jump targets
 * halted flag and the write qualifier
 */

`timescale 1ns/1ps

module mips_fetch (
   input  logic                          clk,
   input  logic                          rst_b,
   input  mips_pkg::instr_t              inst,
   input  logic [mips_pkg::PC_SEL_W-1:0] pc_sel,
   input  logic                          branch_ne,
   input  logic                          branch_eq,
   input  logic [mips_pkg::XLEN-1:0]     rs_data,
   input  logic                          halt_req,
   output logic [mips_pkg::XLEN-1:0]     pc,
   output logic [mips_pkg::XLEN-1:0]     link_addr,
   output logic                          halted,
   output logic                          run
);

   logic [mips_pkg::XLEN-1:0] nextpc;
   logic [mips_pkg::XLEN-1:0] nextpc_d;
   logic [mips_pkg::XLEN-1:0] branch_target;
   logic [mips_pkg::XLEN-1:0] jump_target;
   logic                      taken;

   // writes of this cycle are allowed only while running
   assign run = ~halted & ~halt_req;

   // return address skips the delay slot
   assign link_addr = pc + 32'd8;

   // offset counts words from the delay slot
   assign branch_target = pc + 32'd4 + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
   assign jump_target   = {pc[31:28], inst.j.target, 2'b00};

   // beq wants eq, bne wants not eq
   assign taken = branch_eq ^ branch_ne;

   always_comb
   begin
      case (pc_sel)
         mips_pkg::PC_BRANCH: nextpc_d = taken ? branch_target : nextpc + 32'd4;
         mips_pkg::PC_JREG:   nextpc_d = rs_data;
         mips_pkg::PC_JUMP:   nextpc_d = jump_target;
         default:             nextpc_d = nextpc + 32'd4;
      endcase
   end

   // the delay slot in nextpc always executes before the target
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc     <= mips_pkg::TEXT_START;
         nextpc <= mips_pkg::TEXT_START + 32'd4;
         halted <= 1'b0;
      end
      else
      begin
         if (run)
         begin
            pc     <= nextpc;
            nextpc <= nextpc_d;
         end
         // sticky until reset
         if (halt_req)
            halted <= 1'b1;
      end
   end

endmodule

//--- rtl/mips_core.sv
/*
 * single-cycle mips core top level
 * decode, alu, register file and fetch
 * immediate, operand, destination and write-back muxes
 */

`timescale 1ns/1ps

module mips_core (
   input  logic                         clk,
   input  logic                         rst_b,
   input  logic [mips_pkg::XLEN-1:0]    inst,
   input  logic [mips_pkg::XLEN-1:0]    mem_rdata,
   output logic [mips_pkg::WADDR_W-1:0] inst_addr,
   output logic [mips_pkg::WADDR_W-1:0] mem_addr,
   output logic [mips_pkg::XLEN-1:0]    mem_wdata,
   output logic                         mem_we,
   output logic                         halted
);

   mips_pkg::instr_t                inst_w;
   logic [mips_pkg::ALU_SEL_W-1:0]  alu_sel;
   logic                            alu_src_imm;
   logic                            imm_signed;
   logic                            reg_dst_rd;
   logic                            reg_we;
   logic [mips_pkg::WB_SEL_W-1:0]   wb_sel;
   logic                            dec_mem_we;
   logic [mips_pkg::PC_SEL_W-1:0]   pc_sel;
   logic                            branch_ne;
   logic                            link;
   logic                            halt_req;
   logic [mips_pkg::XLEN-1:0]       rs_data;
   logic [mips_pkg::XLEN-1:0]       rt_data;
   logic [mips_pkg::XLEN-1:0]       imm_ext;
   logic [mips_pkg::XLEN-1:0]       op_b;
   logic [mips_pkg::XLEN-1:0]       alu_result;
   logic                            branch_eq;
   logic [mips_pkg::REG_W-1:0]      dest;
   logic [mips_pkg::XLEN-1:0]       wb_data;
   logic [mips_pkg::XLEN-1:0]       pc;
   logic [mips_pkg::XLEN-1:0]       link_addr;
   logic                            run;

   assign inst_w = inst;

   // sign or zero extension of the 16-bit immediate
   assign imm_ext = imm_signed ? {{16{inst_w.i.imm[15]}}, inst_w.i.imm}
                               : {16'h0000, inst_w.i.imm};
   assign op_b    = alu_src_imm ? imm_ext : rt_data;

   // jal always targets the link register
   assign dest = link       ? mips_pkg::REG_RA :
                 reg_dst_rd ? inst_w.r.rd      : inst_w.i.rt;

   always_comb
   begin
      case (wb_sel)
         mips_pkg::WB_MEM:  wb_data = mem_rdata;
         mips_pkg::WB_LINK: wb_data = link_addr;
         default:           wb_data = alu_result;
      endcase
   end

   // word addresses toward the memory
   assign inst_addr = pc[31:2];
   assign mem_addr  = alu_result[31:2];
   assign mem_wdata = rt_data;
   // no store once halting
   assign mem_we    = dec_mem_we & run;

   mips_decode u_decode (
      .inst(inst_w), .alu_sel(alu_sel), .alu_src_imm(alu_src_imm),
      .imm_signed(imm_signed), .reg_dst_rd(reg_dst_rd), .reg_we(reg_we),
      .wb_sel(wb_sel), .mem_we(dec_mem_we), .pc_sel(pc_sel),
      .branch_ne(branch_ne), .link(link), .halt_req(halt_req)
   );

   mips_alu u_alu (
      .op_a(rs_data), .op_b(op_b), .shamt(inst_w.r.shamt), .alu_sel(alu_sel),
      .result(alu_result), .branch_eq(branch_eq)
   );

   mips_regfile u_regfile (
      .clk(clk), .rs_addr(inst_w.r.rs), .rt_addr(inst_w.r.rt), .rd_addr(dest),
      .rd_data(wb_data), .we(reg_we & run), .rs_data(rs_data), .rt_data(rt_data)
   );

   mips_fetch u_fetch (
      .clk(clk), .rst_b(rst_b), .inst(inst_w), .pc_sel(pc_sel),
      .branch_ne(branch_ne), .branch_eq(branch_eq), .rs_data(rs_data),
      .halt_req(halt_req), .pc(pc), .link_addr(link_addr), .halted(halted),
      .run(run)
   );

endmodule

//--- verif/tb_mips_mem.sv
/*
 * testbench memory model
 * instruction and data word arrays
 * combinational reads, data write on the rising edge
 */

`timescale 1ns/1ps

module tb_mips_mem #(
   parameter int          IMEM_DEPTH = 64,
   parameter int          DMEM_DEPTH = 256,
   parameter logic [29:0] TEXT_WBASE = 30'h0010_0000,
   parameter logic [29:0] DATA_WBASE = 30'h0400_4000
) (
   input  logic        clk,
   input  logic [29:0] inst_addr,
   output logic [31:0] inst,
   input  logic [29:0] mem_addr,
   input  logic [31:0] mem_wdata,
   input  logic        mem_we,
   output logic [31:0] mem_rdata
);

   // depths are powers of two
   localparam int IAW = $clog2(IMEM_DEPTH);
   localparam int DAW = $clog2(DMEM_DEPTH);

   logic [31:0] imem [IMEM_DEPTH];
   logic [31:0] dmem [DMEM_DEPTH];
   logic [29:0] iidx;
   logic [29:0] didx;
   logic        ihit;
   logic        dhit;

   // offsets from the segment bases
   assign iidx = inst_addr - TEXT_WBASE;
   assign didx = mem_addr - DATA_WBASE;

   // in range when every offset bit above the array index is clear
   assign ihit = (iidx[29:IAW] == '0);
   assign dhit = (didx[29:DAW] == '0);

   // outside the arrays the bus reads zero, which is a nop
   assign inst      = ihit ? imem[iidx[IAW-1:0]] : 32'h0;
   assign mem_rdata = dhit ? dmem[didx[DAW-1:0]] : 32'h0;

   always @(posedge clk)
   begin
      if (mem_we && dhit)
         dmem[didx[DAW-1:0]] <= mem_wdata;
   end

endmodule

//--- verif/tb_mips_core.sv
/*
 * testbench for the single-cycle mips core
 * clock, reset, program assembly and loading
 * directed tests for alu, memory, branches, jumps and halt
 */

`timescale 1ns/1ps

module tb_mips_core #(
   parameter int SEED = 21
);

   localparam logic [31:0] DATA_BASE  = 32'h1001_0000;
   localparam logic [31:0] TEXT_WBASE = mips_pkg::TEXT_START >> 2;
   localparam int          IMEM_DEPTH = 64;
   localparam int          DMEM_DEPTH = 256;
   localparam int          TIMEOUT    = 500;
   localparam int          HOLD       = 20;

   logic        clk;
   logic        rst_b;
   logic [31:0] inst;
   logic [31:0] mem_rdata;
   logic [29:0] inst_addr;
   logic [29:0] mem_addr;
   logic [31:0] mem_wdata;
   logic        mem_we;
   logic        halted;
   integer      seed;
   logic [31:0] prog [$];
   logic [31:0] exp_q [$];

   mips_core DUT (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_rdata(mem_rdata),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_we(mem_we), .halted(halted)
   );

   tb_mips_mem #(
      .IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH),
      .TEXT_WBASE(TEXT_WBASE[29:0]), .DATA_WBASE(DATA_BASE[31:2])
   ) MEM (
      .clk(clk), .inst_addr(inst_addr), .inst(inst), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rdata(mem_rdata)
   );

   always #5 clk = ~clk;

   // instruction encoders
   function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // target given as an index into the program
   function automatic logic [31:0] jtype(input logic [5:0] op, input int idx);
      logic [31:0] w;
      w = TEXT_WBASE + idx;
      return {op, w[25:0]};
   endfunction

   function automatic logic [31:0] sext(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   // preload pattern mixes every bit of the byte address
   function automatic logic [31:0] fill(input int k);
      logic [31:0] a;
      a = DATA_BASE + 4 * k;
      return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
   endfunction

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
      assert (got === expv)
      else
      begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, expv);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_dmem(input int k, input logic [31:0] expv);
      check_word($sformatf("dmem[%0d]", k), MEM.dmem[k], expv);
   endtask

   // load program and data, reset, check reset state, wait for halt
   task automatic run_program();
      int n;
      for (int i = 0; i < IMEM_DEPTH; i++)
         MEM.imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
      for (int i = 0; i < DMEM_DEPTH; i++)
         MEM.dmem[i] = fill(i);
      @(posedge clk);
      rst_b <= 1'b0;
      repeat (2) @(posedge clk);
      rst_b <= 1'b1;
      @(negedge clk);
      check_word("inst_addr", {2'b00, inst_addr}, TEXT_WBASE);
      check_word("halted", {31'h0, halted}, 32'h0);
      check_word("mem_we", {31'h0, mem_we}, 32'h0);
      n = 0;
      while (!halted && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      assert (halted)
      else
      begin
         $display("timeout: halted never rose within %0d cycles", TIMEOUT);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   // after halt the pc stays put and nothing is stored
   task automatic hold_check(input int idx);
      repeat (HOLD)
      begin
         @(negedge clk);
         check_word("halted", {31'h0, halted}, 32'h1);
         check_word("inst_addr", {2'b00, inst_addr}, TEXT_WBASE + idx);
         check_word("mem_we", {31'h0, mem_we}, 32'h0);
      end
   endtask

   // one alu op into r4, stored to the next result word
   task automatic alu_case(input logic [31:0] word, input logic [31:0] expv);
      prog.push_back(word);
      prog.push_back(itype(mips_pkg::OP_SW, 5'd1, 5'd4, 16'(4 * exp_q.size())));
      exp_q.push_back(expv);
   endtask

   task automatic test_alu();
      logic [31:0] a;
      logic [31:0] b;
      logic [15:0] imm;
      logic [4:0]  sh;
      a   = $random(seed);
      b   = $random(seed);
      imm = 16'($random(seed));
      sh  = 5'($random(seed));
      prog.delete();
      exp_q.delete();
      prog.push_back(itype(mips_pkg::OP_LUI, 5'd0, 5'd1, DATA_BASE[31:16]));
      prog.push_back(itype(mips_pkg::OP_LUI, 5'd0, 5'd2, a[31:16]));
      prog.push_back(itype(mips_pkg::OP_ORI, 5'd2, 5'd2, a[15:0]));
      prog.push_back(itype(mips_pkg::OP_LUI, 5'd0, 5'd3, b[31:16]));
      prog.push_back(itype(mips_pkg::OP_ORI, 5'd3, 5'd3, b[15:0]));
      alu_case(rtype(mips_pkg::FN_ADD, 2, 3, 4, 0), a + b);
      alu_case(rtype(mips_pkg::FN_ADDU, 2, 3, 4, 0), a + b);
      alu_case(rtype(mips_pkg::FN_SUB, 2, 3, 4, 0), a - b);
      alu_case(rtype(mips_pkg::FN_SUBU, 2, 3, 4, 0), a - b);
      alu_case(rtype(mips_pkg::FN_AND, 2, 3, 4, 0), a & b);
      alu_case(rtype(mips_pkg::FN_OR, 2, 3, 4, 0), a | b);
      alu_case(rtype(mips_pkg::FN_XOR, 2, 3, 4, 0), a ^ b);
      alu_case(rtype(mips_pkg::FN_NOR, 2, 3, 4, 0), ~(a | b));
      alu_case(rtype(mips_pkg::FN_SLT, 2, 3, 4, 0), {31'h0, $signed(a) < $signed(b)});
      alu_case(rtype(mips_pkg::FN_SLT, 3, 2, 4, 0), {31'h0, $signed(b) < $signed(a)});
      // shifts act on rt
      alu_case(rtype(mips_pkg::FN_SLL, 0, 3, 4, sh), b << sh);
      alu_case(rtype(mips_pkg::FN_SRL, 0, 3, 4, sh), b >> sh);
      alu_case(rtype(mips_pkg::FN_SRA, 0, 3, 4, sh), $signed(b) >>> sh);
      alu_case(itype(mips_pkg::OP_ADDI, 2, 4, imm), a + sext(imm));
      alu_case(itype(mips_pkg::OP_ADDIU, 2, 4, imm), a + sext(imm));
      alu_case(itype(mips_pkg::OP_ANDI, 2, 4, imm), a & {16'h0, imm});
      alu_case(itype(mips_pkg::OP_ORI, 2, 4, imm), a | {16'h0, imm});
      alu_case(itype(mips_pkg::OP_XORI, 2, 4, imm), a ^ {16'h0, imm});
      alu_case(itype(mips_pkg::OP_SLTI, 2, 4, imm), {31'h0, $signed(a) < $signed(sext(imm))});
      alu_case(itype(mips_pkg::OP_LUI, 0, 4, imm), {imm, 16'h0});
      prog.push_back(rtype(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      run_program();
      for (int k = 0; k < exp_q.size(); k++)
         check_dmem(k, exp_q[k]);
   endtask

   // words 64..67 are read, bumped and written to 128..131
   task automatic test_memory();
      logic [15:0] imm [4];
      prog.delete();
      prog.push_back(itype(mips_pkg::OP_LUI, 5'd0, 5'd1, DATA_BASE[31:16]));
      for (int i = 0; i < 4; i++)
      begin
         imm[i] = 16'($random(seed));
         prog.push_back(itype(mips_pkg::OP_LW, 1, 5, 16'(4 * (64 + i))));
         prog.push_back(itype(mips_pkg::OP_ADDIU, 5, 5, imm[i]));
         prog.push_back(itype(mips_pkg::OP_SW, 1, 5, 16'(4 * (128 + i))));
      end
      prog.push_back(rtype(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      run_program();
      for (int i = 0; i < 4; i++)
         check_dmem(128 + i, fill(64 + i) + sext(imm[i]));
   endtask

   // each branch skips one word ahead, offset counts from the delay slot
   task automatic test_branch();
      logic [7:0] written;
      prog.delete();
      prog.push_back(itype(mips_pkg::OP_LUI, 0, 1, DATA_BASE[31:16]));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 2, 16'd5));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 3, 16'd5));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 6, 16'd7));
      prog.push_back(itype(mips_pkg::OP_BEQ, 2, 3, 16'd2));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd0));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd4));
      prog.push_back(itype(mips_pkg::OP_BNE, 2, 3, 16'd2));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd8));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd12));
      prog.push_back(itype(mips_pkg::OP_BEQ, 2, 6, 16'd2));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd16));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd20));
      prog.push_back(itype(mips_pkg::OP_BNE, 2, 6, 16'd2));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd24));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd28));
      prog.push_back(rtype(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      run_program();
      // taken branches skip words 1 and 7
      written = 8'b0111_1101;
      for (int k = 0; k < 8; k++)
         check_dmem(k, written[k] ? 32'd5 : fill(k));
   endtask

   task automatic test_jump();
      prog.delete();
      prog.push_back(itype(mips_pkg::OP_LUI, 0, 1, DATA_BASE[31:16]));
      prog.push_back(jtype(mips_pkg::OP_JAL, 10));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 8, 16'h11));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 8, 16'd4));
      prog.push_back(jtype(mips_pkg::OP_J, 7));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 9, 16'h22));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 1, 16'd12));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 9, 16'd16));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 10, 16'd20));
      prog.push_back(rtype(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      // subroutine saves r31 and returns with a delay slot
      prog.push_back(itype(mips_pkg::OP_SW, 1, 31, 16'd0));
      prog.push_back(rtype(mips_pkg::FN_JR, 31, 0, 0, 0));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 10, 16'h33));
      run_program();
      check_dmem(0, mips_pkg::TEXT_START + 32'd4 + 32'd8);
      check_dmem(1, 32'h11);
      check_dmem(3, fill(3));
      check_dmem(4, 32'h22);
      check_dmem(5, 32'h33);
   endtask

   task automatic test_halt();
      prog.delete();
      prog.push_back(itype(mips_pkg::OP_LUI, 0, 1, DATA_BASE[31:16]));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 2, 16'h55));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd0));
      prog.push_back(rtype(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd4));
      run_program();
      hold_check(3);
      check_dmem(0, 32'h55);
      check_dmem(1, fill(1));
      // opcode 0x3f is not decoded
      prog.delete();
      prog.push_back(itype(mips_pkg::OP_LUI, 0, 1, DATA_BASE[31:16]));
      prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 2, 16'h66));
      prog.push_back(itype(6'h3f, 1, 2, 16'd8));
      prog.push_back(itype(mips_pkg::OP_SW, 1, 2, 16'd8));
      run_program();
      hold_check(2);
      check_dmem(2, fill(2));
   endtask

   initial
   begin
      clk   = 1'b0;
      rst_b = 1'b0;
      seed  = SEED;
      test_alu();
      test_memory();
      test_branch();
      test_jump();
      test_halt();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- verilog.f
rtl/mips_pkg.sv
rtl/mips_decode.sv
rtl/mips_alu.sv
rtl/mips_regfile.sv
rtl/mips_fetch.sv
rtl/mips_core.sv
verif/tb_mips_mem.sv
verif/tb_mips_core.sv

//--- Makefile
# Verilator flow for the single-cycle mips core

VERILATOR ?= verilator
TOP       ?= tb_mips_core
SEED      ?= 21
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= verilog.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD)/sim: $(FILELIST) $(wildcard rtl/*.sv) $(wildcard verif/*.sv)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(BUILD) -o sim

sim: $(BUILD)/sim
	./$(BUILD)/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
